// File: snes_loader.f
+incdir+.
snes_loader_pkg.sv
rom_header_detect.sv
wram_fill.sv
cheat_code_assembler.sv
cheat_code_fifo.sv
cart_apb_regs.sv
snes_loader_top.sv
tb_snes_loader_assert.sv
tb_snes_loader.sv

// File: Makefile
TOP = tb_snes_loader

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f snes_loader.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

// File: tb_snes_loader.sv
`default_nettype none
`timescale 1ns/1ps

`include "snes_loader_cfg.svh"

module tb_snes_loader;

	localparam int FILL_WORDS = 1 << `FILL_ADDR_W;
	localparam int WATCHDOG_CYCLES = 6 * FILL_WORDS + 20000;

	logic clk_sys;
	logic RESET;
	logic dl_active;
	snes_loader_pkg::dl_index_t dl_index;
	snes_loader_pkg::dl_addr_t dl_addr;
	snes_loader_pkg::dl_data_t dl_data;
	logic dl_wr;
	logic psel;
	logic penable;
	logic pwrite;
	snes_loader_pkg::apb_addr_t paddr;
	snes_loader_pkg::apb_data_t pwdata;
	snes_loader_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;
	snes_loader_pkg::fill_addr_t fill_addr;
	snes_loader_pkg::fill_data_t fill_data;
	logic fill_we;
	logic pal;

	// Fill monitor state armed by the stimulus
	logic fill_watch;
	snes_loader_pkg::fill_pattern_e cur_pattern;
	int fill_cycles;
	snes_loader_pkg::fill_addr_t next_addr;

	snes_loader_top dut_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.dl_active(dl_active), .dl_index(dl_index), .dl_addr(dl_addr),
		.dl_data(dl_data), .dl_wr(dl_wr),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.fill_addr(fill_addr), .fill_data(fill_data), .fill_we(fill_we), .pal(pal)
	);

	always #50 clk_sys = ~clk_sys;

	// ========================================================================
	// Reference model
	// ========================================================================
	function automatic snes_loader_pkg::mem_mask_t exp_rom_mask(input logic [3:0] size);
		longint span;
		span = longint'(1) << (size + 10);
		return snes_loader_pkg::mem_mask_t'(span - 1);
	endfunction

	// Zero size means no save RAM at all
	function automatic snes_loader_pkg::mem_mask_t exp_ram_mask(input logic [3:0] size);
		if (size == 4'd0) begin
			return '0;
		end
		return exp_rom_mask(size);
	endfunction

	function automatic snes_loader_pkg::rom_type_t exp_rom_type(
			input snes_loader_pkg::header_mode_e mode, input snes_loader_pkg::dl_data_t w0);
		case (mode)
			snes_loader_pkg::HDR_AUTO:    return w0[15:8];
			snes_loader_pkg::HDR_HIROM:   return 8'd1;
			snes_loader_pkg::HDR_EXHIROM: return 8'd2;
			default:                      return 8'd0;
		endcase
	endfunction

	function automatic snes_loader_pkg::fill_data_t exp_fill_data(
			input snes_loader_pkg::fill_pattern_e pattern, input snes_loader_pkg::fill_addr_t addr);
		if (pattern == snes_loader_pkg::FILL_9966) begin
			return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
		end
		if (pattern == snes_loader_pkg::FILL_00FF) begin
			return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
		end
		return (pattern == snes_loader_pkg::FILL_55) ? 8'h55 : 8'hFF;
	endfunction

	function automatic snes_loader_pkg::apb_data_t exp_status(input int count, input logic ovf);
		snes_loader_pkg::apb_data_t word;
		word = '0;
		word[2:0] = count[2:0];
		word[8] = ovf;
		return word;
	endfunction

	// ========================================================================
	// Compare tasks
	// ========================================================================
	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_mask(input string name, input snes_loader_pkg::mem_mask_t got,
			input snes_loader_pkg::mem_mask_t exp);
		if (got !== exp) begin
			$display("error: time %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_rom_type(input string name, input snes_loader_pkg::rom_type_t got,
			input snes_loader_pkg::rom_type_t exp);
		if (got !== exp) begin
			$display("error: time %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_fill(input string name, input snes_loader_pkg::fill_data_t got,
			input snes_loader_pkg::fill_data_t exp);
		if (got !== exp) begin
			$display("error: time %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input snes_loader_pkg::fill_addr_t got,
			input snes_loader_pkg::fill_addr_t exp);
		if (got !== exp) begin
			$display("error: time %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_code(input string name, input snes_loader_pkg::cheat_code_t got,
			input snes_loader_pkg::cheat_code_t exp);
		if (got !== exp) begin
			$display("error: time %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_data(input string name, input snes_loader_pkg::apb_data_t got,
			input snes_loader_pkg::apb_data_t exp);
		if (got !== exp) begin
			$display("error: time %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: time %0t %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	// ========================================================================
	// Bus and download drivers
	// ========================================================================
	task automatic apb_write(input snes_loader_pkg::apb_addr_t addr,
			input snes_loader_pkg::apb_data_t data, input logic exp_err);
		logic err;
		logic rdy;
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(negedge clk_sys);
		err = pslverr;
		rdy = pready;
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		check_bit("pready", rdy, 1'b1);
		check_bit("pslverr", err, exp_err);
	endtask

	task automatic apb_read(input snes_loader_pkg::apb_addr_t addr,
			output snes_loader_pkg::apb_data_t data, input logic exp_err);
		logic err;
		logic rdy;
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(negedge clk_sys);
		data = prdata;
		err  = pslverr;
		rdy  = pready;
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
		check_bit("pready", rdy, 1'b1);
		check_bit("pslverr", err, exp_err);
	endtask

	// Word is sampled on the next edge so back to back calls stream without gaps
	task automatic dl_word(input snes_loader_pkg::dl_index_t index,
			input snes_loader_pkg::dl_addr_t addr, input snes_loader_pkg::dl_data_t data);
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index  <= index;
		dl_addr   <= addr;
		dl_data   <= data;
		dl_wr     <= 1'b1;
	endtask

	task automatic dl_finish();
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
	endtask

	task automatic send_code(input snes_loader_pkg::cheat_code_t code);
		snes_loader_pkg::apb_data_t words [4];
		words[0] = code[127:96];
		words[1] = code[95:64];
		words[2] = code[63:32];
		words[3] = code[31:0];
		for (int i = 0; i < 4; i++) begin
			dl_word(`CODE_INDEX, snes_loader_pkg::dl_addr_t'(i * 4), words[i][15:0]);
			dl_word(`CODE_INDEX, snes_loader_pkg::dl_addr_t'(i * 4 + 2), words[i][31:16]);
		end
		dl_finish();
	endtask

	task automatic read_code(output snes_loader_pkg::cheat_code_t code);
		snes_loader_pkg::apb_data_t rd;
		apb_read(`REG_CODE_FLAGS, rd, 1'b0);
		code[127:96] = rd;
		apb_read(`REG_CODE_ADDR, rd, 1'b0);
		code[95:64] = rd;
		apb_read(`REG_CODE_CMP, rd, 1'b0);
		code[63:32] = rd;
		apb_read(`REG_CODE_REPL, rd, 1'b0);
		code[31:0] = rd;
	endtask

	// ========================================================================
	// Test cases
	// ========================================================================
	task automatic header_case(input snes_loader_pkg::header_mode_e mode,
			input snes_loader_pkg::region_sel_e region);
		snes_loader_pkg::dl_data_t w0;
		snes_loader_pkg::dl_data_t w2;
		snes_loader_pkg::dl_data_t size_word;
		snes_loader_pkg::dl_data_t ram_word;
		snes_loader_pkg::dl_addr_t base;
		snes_loader_pkg::apb_data_t rd;
		logic [3:0] rom_size;
		logic [3:0] ram_size;
		logic exp_pal;
		w0 = snes_loader_pkg::dl_data_t'($urandom);
		if (w0[7:0] == 8'd0) begin
			w0[0] = 1'b1;
		end
		w2 = snes_loader_pkg::dl_data_t'($urandom);
		size_word = snes_loader_pkg::dl_data_t'($urandom);
		ram_word = snes_loader_pkg::dl_data_t'($urandom);
		case (mode)
			snes_loader_pkg::HDR_HIROM:   base = `HIROM_SIZE_OFF + `HEADER_SKIP;
			snes_loader_pkg::HDR_EXHIROM: base = `EXHIROM_SIZE_OFF + `HEADER_SKIP;
			default:                      base = '0;
		endcase
		apb_write(`REG_CTRL, snes_loader_pkg::apb_data_t'(mode) |
			(snes_loader_pkg::apb_data_t'(region) << 4), 1'b0);
		dl_word(snes_loader_pkg::dl_index_t'(`CART_INDEX), '0, w0);
		dl_word(snes_loader_pkg::dl_index_t'(`CART_INDEX), 25'd2, w2);
		if (mode != snes_loader_pkg::HDR_AUTO) begin
			dl_word(snes_loader_pkg::dl_index_t'(`CART_INDEX), base, size_word);
			dl_word(snes_loader_pkg::dl_index_t'(`CART_INDEX), base + `RAM_SIZE_DELTA, ram_word);
		end
		// One more word so the masks catch up with the sizes
		dl_word(snes_loader_pkg::dl_index_t'(`CART_INDEX), base + 25'd4, 16'h0000);
		dl_finish();
		if (mode == snes_loader_pkg::HDR_AUTO) begin
			rom_size = w0[3:0];
			ram_size = w0[7:4];
		end else begin
			rom_size = size_word[11:8];
			ram_size = ram_word[3:0];
		end
		exp_pal = (region == snes_loader_pkg::REGION_AUTO) ? w2[8] :
			(region == snes_loader_pkg::REGION_PAL);
		apb_read(`REG_ROM_MASK, rd, 1'b0);
		check_mask("rom_mask", rd[23:0], exp_rom_mask(rom_size));
		apb_read(`REG_RAM_MASK, rd, 1'b0);
		check_mask("ram_mask", rd[23:0], exp_ram_mask(ram_size));
		apb_read(`REG_CART_INFO, rd, 1'b0);
		check_rom_type("rom_type", rd[7:0], exp_rom_type(mode, w0));
		check_bit("cart_info pal", rd[8], exp_pal);
		@(negedge clk_sys);
		check_bit("pal", pal, exp_pal);
	endtask

	task automatic fill_case(input snes_loader_pkg::fill_pattern_e pattern);
		snes_loader_pkg::apb_data_t rd;
		// A sweep left over from earlier downloads runs out first
		do begin
			@(negedge clk_sys);
		end while (fill_we);
		apb_write(`REG_CTRL, snes_loader_pkg::apb_data_t'(pattern) << 8, 1'b0);
		cur_pattern = pattern;
		next_addr   = '0;
		fill_cycles = 0;
		fill_watch  = 1'b1;
		dl_word(snes_loader_pkg::dl_index_t'(`CART_INDEX), '0, 16'h0000);
		dl_finish();
		apb_read(`REG_CART_INFO, rd, 1'b0);
		check_bit("clearing", rd[9], 1'b1);
		while (fill_cycles < FILL_WORDS) begin
			@(negedge clk_sys);
		end
		repeat (2) @(posedge clk_sys);
		fill_watch = 1'b0;
		apb_read(`REG_CART_INFO, rd, 1'b0);
		check_bit("clearing", rd[9], 1'b0);
	endtask

	// Compares every fill write against the pattern rule
	always @(negedge clk_sys) begin
		if (fill_watch) begin
			if (fill_we) begin
				if (fill_cycles >= FILL_WORDS) begin
					$display("fill_we stayed high for more than %0d cycles", FILL_WORDS);
					stop_run();
				end
				check_addr("fill_addr", fill_addr, next_addr);
				check_fill("fill_data", fill_data, exp_fill_data(cur_pattern, next_addr));
				next_addr   = next_addr + 1'b1;
				fill_cycles = fill_cycles + 1;
			end else if (fill_cycles != 0 && fill_cycles < FILL_WORDS) begin
				$display("fill_we dropped after %0d of %0d cycles", fill_cycles, FILL_WORDS);
				stop_run();
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		stop_run();
	end

	initial begin
		snes_loader_pkg::apb_data_t rd;
		snes_loader_pkg::cheat_code_t codes [5];
		snes_loader_pkg::cheat_code_t got;
		void'($urandom(91106));
		clk_sys     = 1'b0;
		RESET       = 1'b1;
		dl_active   = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_data     = '0;
		dl_wr       = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		fill_watch  = 1'b0;
		cur_pattern = snes_loader_pkg::FILL_9966;
		fill_cycles = 0;
		next_addr   = '0;
		repeat (16) @(posedge clk_sys);
		RESET <= 1'b0;

		// Control register and decode errors
		apb_write(`REG_CTRL, 32'h0000_0233, 1'b0);
		apb_read(`REG_CTRL, rd, 1'b0);
		check_data("REG_CTRL", rd, 32'h0000_0233);
		apb_read(8'h30, rd, 1'b1);
		apb_write(`REG_CART_INFO, 32'h0, 1'b1);

		header_case(snes_loader_pkg::HDR_AUTO, snes_loader_pkg::REGION_AUTO);
		header_case(snes_loader_pkg::HDR_HIROM, snes_loader_pkg::REGION_PAL);
		header_case(snes_loader_pkg::HDR_EXHIROM, snes_loader_pkg::REGION_NTSC);

		// One code more than the queue holds
		for (int i = 0; i < 5; i++) begin
			codes[i] = {$urandom, $urandom, $urandom, $urandom};
			send_code(codes[i]);
		end
		apb_read(`REG_CODE_STATUS, rd, 1'b0);
		check_data("REG_CODE_STATUS", rd, exp_status(`CODE_FIFO_DEPTH, 1'b1));
		for (int i = 0; i < `CODE_FIFO_DEPTH; i++) begin
			read_code(got);
			check_code("head", got, codes[i]);
			apb_write(`REG_CODE_POP, 32'h0, 1'b0);
		end
		apb_read(`REG_CODE_STATUS, rd, 1'b0);
		check_data("REG_CODE_STATUS", rd, exp_status(0, 1'b1));
		apb_read(`REG_CODE_FLAGS, rd, 1'b1);
		apb_write(`REG_CODE_POP, 32'h0, 1'b1);
		apb_write(`REG_CODE_STATUS, 32'h0000_0100, 1'b0);
		apb_read(`REG_CODE_STATUS, rd, 1'b0);
		check_data("REG_CODE_STATUS", rd, exp_status(0, 1'b0));

		for (int p = 0; p < 4; p++) begin
			fill_case(snes_loader_pkg::fill_pattern_e'(p));
		end

		// Queued codes are dropped by the next cartridge
		send_code({$urandom, $urandom, $urandom, $urandom});
		send_code({$urandom, $urandom, $urandom, $urandom});
		apb_read(`REG_CODE_STATUS, rd, 1'b0);
		check_data("REG_CODE_STATUS", rd, exp_status(2, 1'b0));
		dl_word(snes_loader_pkg::dl_index_t'(`CART_INDEX), '0, 16'h0000);
		dl_finish();
		apb_read(`REG_CODE_STATUS, rd, 1'b0);
		check_data("REG_CODE_STATUS", rd, exp_status(0, 1'b0));

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_snes_loader_assert.sv
`default_nettype none
`timescale 1ns/1ps

`include "snes_loader_cfg.svh"

module tb_snes_loader_assert (
	input wire                          clk_sys,
	input wire                          RESET,
	input wire                          psel,
	input wire                          penable,
	input wire                          pready,
	input wire                          pslverr,
	input wire                          fill_we,
	input wire                          cart_start,
	input snes_loader_pkg::fill_addr_t  fill_addr,
	input snes_loader_pkg::code_count_t count
);

	// APB slave without wait states
	ready_high: assert property (@(posedge clk_sys) disable iff (RESET) pready)
		else $error("pready went low");

	// Sweep walks the addresses one by one, a restart or the last address excepted
	fill_step: assert property (@(posedge clk_sys) disable iff (RESET)
		(fill_we && !cart_start && fill_addr != '1) |=>
		(fill_we && fill_addr == $past(fill_addr) + 1'b1))
		else $error("fill_addr did not step by one during the sweep");

	count_limit: assert property (@(posedge clk_sys) disable iff (RESET)
		count <= snes_loader_pkg::code_count_t'(`CODE_FIFO_DEPTH))
		else $error("code queue count above its depth");

	err_in_access: assert property (@(posedge clk_sys) disable iff (RESET)
		pslverr |-> (psel && penable))
		else $error("pslverr outside an APB access phase");

endmodule

bind snes_loader_top tb_snes_loader_assert assert_i (
	.clk_sys(clk_sys), .RESET(RESET),
	.psel(psel), .penable(penable), .pready(pready), .pslverr(pslverr),
	.fill_we(fill_we), .cart_start(cart_start), .fill_addr(fill_addr),
	.count(count)
);

`default_nettype wire

// File: snes_loader_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "snes_loader_cfg.svh"

module snes_loader_top (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire                         dl_active,
	input  snes_loader_pkg::dl_index_t  dl_index,
	input  snes_loader_pkg::dl_addr_t   dl_addr,
	input  snes_loader_pkg::dl_data_t   dl_data,
	input  wire                         dl_wr,
	input  wire                         psel,
	input  wire                         penable,
	input  wire                         pwrite,
	input  snes_loader_pkg::apb_addr_t  paddr,
	input  snes_loader_pkg::apb_data_t  pwdata,
	output snes_loader_pkg::apb_data_t  prdata,
	output logic                        pready,
	output logic                        pslverr,
	output snes_loader_pkg::fill_addr_t fill_addr,
	output snes_loader_pkg::fill_data_t fill_data,
	output logic                        fill_we,
	output logic                        pal
);

	logic cart_download;
	logic code_download;
	logic cart_dl_q;
	logic cart_start;
	logic clearing;
	snes_loader_pkg::header_mode_e header_mode;
	snes_loader_pkg::region_sel_e region_sel;
	snes_loader_pkg::fill_pattern_e fill_pattern;
	snes_loader_pkg::rom_type_t rom_type;
	snes_loader_pkg::mem_mask_t rom_mask;
	snes_loader_pkg::mem_mask_t ram_mask;
	snes_loader_pkg::cheat_code_t code;
	snes_loader_pkg::cheat_code_t head;
	snes_loader_pkg::code_count_t count;
	logic code_push;
	logic code_pop;
	logic ovf_clear;
	logic empty;
	logic overflow;

	// Download type from the host index
	assign cart_download = dl_active & (dl_index[5:0] == `CART_INDEX);
	assign code_download = dl_active & (dl_index == `CODE_INDEX);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
		end else begin
			cart_dl_q <= cart_download;
		end
	end

	// First cycle of a cartridge download
	assign cart_start = cart_download & ~cart_dl_q;

	rom_header_detect hdr_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.cart_download(cart_download), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.header_mode(header_mode), .region_sel(region_sel),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	wram_fill fill_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.cart_start(cart_start), .fill_pattern(fill_pattern),
		.fill_addr(fill_addr), .fill_data(fill_data),
		.fill_we(fill_we), .clearing(clearing)
	);

	cheat_code_assembler asm_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.code_download(code_download), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.code(code), .code_push(code_push)
	);

	cheat_code_fifo #(
		.DEPTH(`CODE_FIFO_DEPTH)
	) fifo_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.flush(cart_start), .code_push(code_push), .code(code),
		.code_pop(code_pop), .ovf_clear(ovf_clear),
		.head(head), .count(count), .empty(empty), .overflow(overflow)
	);

	cart_apb_regs regs_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask),
		.pal(pal), .clearing(clearing),
		.head(head), .count(count), .empty(empty), .overflow(overflow),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.header_mode(header_mode), .region_sel(region_sel), .fill_pattern(fill_pattern),
		.code_pop(code_pop), .ovf_clear(ovf_clear)
	);

endmodule

`default_nettype wire

// File: cart_apb_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "snes_loader_cfg.svh"

module cart_apb_regs (
	input  wire                            clk_sys,
	input  wire                            RESET,
	input  wire                            psel,
	input  wire                            penable,
	input  wire                            pwrite,
	input  snes_loader_pkg::apb_addr_t     paddr,
	input  snes_loader_pkg::apb_data_t     pwdata,
	input  snes_loader_pkg::rom_type_t     rom_type,
	input  snes_loader_pkg::mem_mask_t     rom_mask,
	input  snes_loader_pkg::mem_mask_t     ram_mask,
	input  wire                            pal,
	input  wire                            clearing,
	input  snes_loader_pkg::cheat_code_t   head,
	input  snes_loader_pkg::code_count_t   count,
	input  wire                            empty,
	input  wire                            overflow,
	output snes_loader_pkg::apb_data_t     prdata,
	output logic                           pready,
	output logic                           pslverr,
	output snes_loader_pkg::header_mode_e  header_mode,
	output snes_loader_pkg::region_sel_e   region_sel,
	output snes_loader_pkg::fill_pattern_e fill_pattern,
	output logic                           code_pop,
	output logic                           ovf_clear
);

	logic access;
	logic wr_access;
	logic err;

	// No wait states
	assign pready    = 1'b1;
	assign access    = psel & penable;
	assign wr_access = access & pwrite;

	// ========================================================================
	// Control register
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			header_mode  <= snes_loader_pkg::HDR_AUTO;
			region_sel   <= snes_loader_pkg::REGION_AUTO;
			fill_pattern <= snes_loader_pkg::FILL_9966;
		end else if (wr_access && paddr == `REG_CTRL) begin
			header_mode  <= snes_loader_pkg::header_mode_e'(pwdata[2:0]);
			region_sel   <= snes_loader_pkg::region_sel_e'(pwdata[5:4]);
			fill_pattern <= snes_loader_pkg::fill_pattern_e'(pwdata[9:8]);
		end
	end

	// ========================================================================
	// Read mux and error decode
	// ========================================================================
	always_comb begin
		prdata = '0;
		err    = 1'b0;
		case (paddr)
			`REG_CTRL: begin
				prdata = {22'd0, fill_pattern, 2'd0, region_sel, 1'b0, header_mode};
			end
			`REG_CART_INFO: begin
				prdata = {22'd0, clearing, pal, rom_type};
				err    = pwrite;
			end
			`REG_ROM_MASK: begin
				prdata = {8'd0, rom_mask};
				err    = pwrite;
			end
			`REG_RAM_MASK: begin
				prdata = {8'd0, ram_mask};
				err    = pwrite;
			end
			`REG_CODE_STATUS: begin
				prdata = {23'd0, overflow, 5'd0, count};
			end
			`REG_CODE_FLAGS: begin
				prdata = head[127:96];
				err    = pwrite | empty;
			end
			`REG_CODE_ADDR: begin
				prdata = head[95:64];
				err    = pwrite | empty;
			end
			`REG_CODE_CMP: begin
				prdata = head[63:32];
				err    = pwrite | empty;
			end
			`REG_CODE_REPL: begin
				prdata = head[31:0];
				err    = pwrite | empty;
			end
			`REG_CODE_POP: begin
				// Write only, a read returns zero
				err = pwrite & empty;
			end
			default: begin
				err = 1'b1;
			end
		endcase
	end

	assign pslverr = access & err;

	// Pulses land on the edge that closes the access phase
	assign code_pop  = wr_access & (paddr == `REG_CODE_POP) & ~empty;
	assign ovf_clear = wr_access & (paddr == `REG_CODE_STATUS) & pwdata[8];

endmodule

`default_nettype wire

// File: cheat_code_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "snes_loader_cfg.svh"

module cheat_code_fifo #(
	parameter int DEPTH = `CODE_FIFO_DEPTH
) (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire                          flush,
	input  wire                          code_push,
	input  snes_loader_pkg::cheat_code_t code,
	input  wire                          code_pop,
	input  wire                          ovf_clear,
	output snes_loader_pkg::cheat_code_t head,
	output snes_loader_pkg::code_count_t count,
	output logic                         empty,
	output logic                         overflow
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH) + 1;

	snes_loader_pkg::cheat_code_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] fill_cnt;
	logic full;
	logic do_pop;
	logic do_push;

	assign full  = (fill_cnt == CNT_W'(DEPTH));
	assign empty = (fill_cnt == '0);

	// A pop frees the slot a push in the same cycle needs
	assign do_pop  = code_pop & ~empty;
	assign do_push = code_push & (~full | do_pop);

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr] <= code;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			fill_cnt <= '0;
		end else if (flush) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			fill_cnt <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				fill_cnt <= fill_cnt + 1'b1;
			end else if (do_pop && !do_push) begin
				fill_cnt <= fill_cnt - 1'b1;
			end
		end
	end

	// Sticky until software clears it, a flush leaves it alone
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			overflow <= 1'b0;
		end else if (code_push && !do_push) begin
			overflow <= 1'b1;
		end else if (ovf_clear) begin
			overflow <= 1'b0;
		end
	end

	assign head  = mem[rd_ptr];
	assign count = snes_loader_pkg::code_count_t'(fill_cnt);

endmodule

`default_nettype wire

// File: cheat_code_assembler.sv
`default_nettype none
`timescale 1ns/1ps

module cheat_code_assembler (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire                          code_download,
	input  wire                          dl_wr,
	input  snes_loader_pkg::dl_addr_t    dl_addr,
	input  snes_loader_pkg::dl_data_t    dl_data,
	output snes_loader_pkg::cheat_code_t code,
	output logic                         code_push
);

	logic code_wr;

	assign code_wr = code_download & dl_wr;

	// Words arrive low half first, big endian values are left to the host
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[3:0])
				4'd0:  code[111:96]  <= dl_data;
				4'd2:  code[127:112] <= dl_data;
				4'd4:  code[79:64]   <= dl_data;
				4'd6:  code[95:80]   <= dl_data;
				4'd8:  code[47:32]   <= dl_data;
				4'd10: code[63:48]   <= dl_data;
				4'd12: code[15:0]    <= dl_data;
				4'd14: code[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

	// Last word completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_push <= 1'b0;
		end else begin
			code_push <= code_wr && (dl_addr[3:0] == 4'd14);
		end
	end

endmodule

`default_nettype wire

// File: wram_fill.sv
`default_nettype none
`timescale 1ns/1ps

module wram_fill (
	input  wire                            clk_sys,
	input  wire                            RESET,
	input  wire                            cart_start,
	input  snes_loader_pkg::fill_pattern_e fill_pattern,
	output snes_loader_pkg::fill_addr_t    fill_addr,
	output snes_loader_pkg::fill_data_t    fill_data,
	output logic                           fill_we,
	output logic                           clearing
);

	snes_loader_pkg::fill_state_e state;

	// One full sweep per cartridge download, restarted by a new start
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= snes_loader_pkg::FILL_IDLE;
			fill_addr <= '0;
		end else if (cart_start) begin
			state     <= snes_loader_pkg::FILL_RUN;
			fill_addr <= '0;
		end else begin
			case (state)
				snes_loader_pkg::FILL_RUN: begin
					fill_addr <= fill_addr + 1'b1;
					if (&fill_addr) begin
						state <= snes_loader_pkg::FILL_IDLE;
					end
				end
				default: begin
					fill_addr <= '0;
				end
			endcase
		end
	end

	assign fill_we  = (state == snes_loader_pkg::FILL_RUN);
	assign clearing = fill_we;

	// Power-on patterns of the different console revisions
	always_comb begin
		case (fill_pattern)
			snes_loader_pkg::FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			snes_loader_pkg::FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			snes_loader_pkg::FILL_55:   fill_data = 8'h55;
			default:                    fill_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// File: rom_header_detect.sv
`default_nettype none
`timescale 1ns/1ps

`include "snes_loader_cfg.svh"

module rom_header_detect (
	input  wire                           clk_sys,
	input  wire                           RESET,
	input  wire                           cart_download,
	input  wire                           dl_wr,
	input  snes_loader_pkg::dl_addr_t     dl_addr,
	input  snes_loader_pkg::dl_data_t     dl_data,
	input  snes_loader_pkg::header_mode_e header_mode,
	input  snes_loader_pkg::region_sel_e  region_sel,
	output snes_loader_pkg::rom_type_t    rom_type,
	output snes_loader_pkg::mem_mask_t    rom_mask,
	output snes_loader_pkg::mem_mask_t    ram_mask,
	output logic                          pal
);

	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic rom_region;
	logic forced;
	snes_loader_pkg::dl_addr_t size_addr;
	snes_loader_pkg::dl_addr_t ram_addr;

	// Location of the size word when the mapper is forced
	always_comb begin
		forced = 1'b1;
		case (header_mode)
			snes_loader_pkg::HDR_LOROM:
				size_addr = snes_loader_pkg::dl_addr_t'(`LOROM_SIZE_OFF + `HEADER_SKIP);
			snes_loader_pkg::HDR_HIROM:
				size_addr = snes_loader_pkg::dl_addr_t'(`HIROM_SIZE_OFF + `HEADER_SKIP);
			snes_loader_pkg::HDR_EXHIROM:
				size_addr = snes_loader_pkg::dl_addr_t'(`EXHIROM_SIZE_OFF + `HEADER_SKIP);
			default: begin
				forced    = 1'b0;
				size_addr = '0;
			end
		endcase
	end

	assign ram_addr = size_addr + snes_loader_pkg::dl_addr_t'(`RAM_SIZE_DELTA);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'd0;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
			rom_type   <= 8'd0;
			rom_mask   <= 24'd0;
			ram_mask   <= 24'd0;
			pal        <= 1'b0;
		end else if (cart_download) begin
			if (dl_wr) begin
				if (dl_addr == '0) begin
					// Loader word: {type, ram size, rom size}
					if (header_mode == snes_loader_pkg::HDR_AUTO && dl_data[7:0] != 8'd0) begin
						{ram_size, rom_size} <= dl_data[7:0];
					end else begin
						rom_size <= 4'hC;
						ram_size <= 4'h0;
					end
					case (header_mode)
						snes_loader_pkg::HDR_NONE:    rom_type <= 8'd0;
						snes_loader_pkg::HDR_LOROM:   rom_type <= 8'd0;
						snes_loader_pkg::HDR_HIROM:   rom_type <= 8'd1;
						snes_loader_pkg::HDR_EXHIROM: rom_type <= 8'd2;
						default:                      rom_type <= dl_data[15:8];
					endcase
				end

				if (dl_addr == snes_loader_pkg::dl_addr_t'(2)) begin
					rom_region <= dl_data[8];
				end

				if (forced && dl_addr == size_addr) begin
					rom_size <= dl_data[11:8];
				end
				if (forced && dl_addr == ram_addr) begin
					ram_size <= dl_data[3:0];
				end

				// Masks trail the sizes by one write
				rom_mask <= (24'd1024 << rom_size) - 24'd1;
				ram_mask <= (ram_size != 4'd0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
			end
		end else begin
			pal <= (region_sel == snes_loader_pkg::REGION_AUTO) ? rom_region : region_sel[0];
		end
	end

endmodule

`default_nettype wire

// File: snes_loader_pkg.sv
`default_nettype none

`include "snes_loader_cfg.svh"

package snes_loader_pkg;

	// Download stream
	typedef logic [`DL_ADDR_W-1:0] dl_addr_t;
	typedef logic [15:0]           dl_data_t;
	typedef logic [7:0]            dl_index_t;

	// Cartridge information
	typedef logic [7:0]  rom_type_t;
	typedef logic [23:0] mem_mask_t;

	// Work RAM fill port
	typedef logic [`FILL_ADDR_W-1:0] fill_addr_t;
	typedef logic [7:0]              fill_data_t;

	// Flags [127:96], address [95:64], compare [63:32], replace [31:0]
	typedef logic [127:0] cheat_code_t;
	typedef logic [$clog2(`CODE_FIFO_DEPTH):0] code_count_t;

	// APB
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd2,
		REGION_PAL  = 2'd3
	} region_sel_e;

	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_pattern_e;

	typedef enum logic {
		FILL_IDLE = 1'b0,
		FILL_RUN  = 1'b1
	} fill_state_e;

endpackage

`default_nettype wire

// File: snes_loader_cfg.svh
`ifndef SNES_LOADER_CFG_SVH
`define SNES_LOADER_CFG_SVH

// ==========================================================================
// Widths and sizes
// ==========================================================================
`define DL_ADDR_W        25
`define FILL_ADDR_W      17
`define CODE_FIFO_DEPTH  4

// Copier header in front of the ROM image
`define HEADER_SKIP      512

// Offset of the ROM size word inside the internal header, per mapper
`define LOROM_SIZE_OFF   'h7FD6
`define HIROM_SIZE_OFF   'hFFD6
`define EXHIROM_SIZE_OFF 'h40FFD6
`define RAM_SIZE_DELTA   2

// Download index values from the host
`define CART_INDEX       6'd0
`define CODE_INDEX       8'hFF

// ==========================================================================
// APB register map (byte offsets)
// ==========================================================================
`define REG_CTRL         8'h00
`define REG_CART_INFO    8'h04
`define REG_ROM_MASK     8'h08
`define REG_RAM_MASK     8'h0C
`define REG_CODE_STATUS  8'h10
`define REG_CODE_FLAGS   8'h14
`define REG_CODE_ADDR    8'h18
`define REG_CODE_CMP     8'h1C
`define REG_CODE_REPL    8'h20
`define REG_CODE_POP     8'h24

`endif
